//--- mbox_pkg.sv
/*
 * Mailbox package: bus widths, register map, response codes, marker words
 * and the AXI-Lite channel structs shared by both mailbox ports
 */
package mbox_pkg;

  // ----------------------------------------------------------------------
  // bus geometry
  // ----------------------------------------------------------------------
  localparam int unsigned ADDR_W    = 6;  // 16-word window per port
  localparam int unsigned DATA_W    = 32;
  localparam int unsigned STRB_W    = DATA_W / 8;
  localparam int unsigned REG_IDX_W = 4;  // word address bits 5:2

  // register map, indices 8..15 are not decoded
  typedef enum logic [REG_IDX_W-1:0] {
    MBOXW  = 4'd0,  // push into outbound fifo
    MBOXR  = 4'd1,  // pop from inbound fifo
    STATUS = 4'd2,  // bit0 inbound empty, bit1 outbound full
    ERROR  = 4'd3,  // bit0 read empty, bit1 write full, clear on read
    IRQS   = 4'd4,  // error irq status, write one to clear
    IRQEN  = 4'd5,  // error irq enable
    IRQP   = 4'd6,  // pending = status & enable
    CTRL   = 4'd7   // bit0 flush outbound, bit1 flush inbound
  } reg_e;

  // AXI response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  typedef logic [DATA_W-1:0] data_t;

  localparam data_t MBOXW_READ_WORD = 32'hFEED_C0DE;  // MBOXW is write only
  localparam data_t EMPTY_READ_WORD = 32'hFEED_DEAD;  // pop from empty mailbox

  // ----------------------------------------------------------------------
  // AXI-Lite channels, flattened into one request and one response word
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic               aw_valid;
    logic [ADDR_W-1:0]  aw_addr;
    logic               w_valid;
    data_t              w_data;
    logic [STRB_W-1:0]  w_strb;
    logic               b_ready;
    logic               ar_valid;
    logic [ADDR_W-1:0]  ar_addr;
    logic               r_ready;
  } lite_req_t;

  typedef struct packed {
    logic               aw_ready;
    logic               w_ready;
    logic               b_valid;
    logic [1:0]         b_resp;
    logic               ar_ready;
    logic               r_valid;
    data_t              r_data;
    logic [1:0]         r_resp;
  } lite_rsp_t;

  // payloads held in the response stages
  typedef struct packed {
    data_t      data;
    logic [1:0] resp;
  } r_chan_t;

  typedef struct packed {
    logic [1:0] resp;
  } b_chan_t;

  // one fifo as seen from a port
  typedef struct packed {
    data_t data;
    logic  strobe;  // push on the writer side, pop on the reader side
    logic  flush;
    logic  flag;    // full on the writer side, empty on the reader side
  } mbox_side_t;

endpackage

//--- mbox_fifo.sv
/*
 * Mailbox FIFO with push, pop and flush over a synchronous circular buffer.
 * One instance serves each direction and data_o always shows the head word
 */
module mbox_fifo #(
  parameter int unsigned MailboxDepth = 8  // at least 2
) (
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            push_i,
  input  logic            pop_i,
  input  logic            flush_i,   // wins over push and pop
  input  mbox_pkg::data_t data_i,
  output mbox_pkg::data_t data_o,
  output logic            full_o,
  output logic            empty_o
);

  localparam int unsigned PtrW = $clog2(MailboxDepth);
  localparam int unsigned CntW = $clog2(MailboxDepth + 1);

  typedef logic [PtrW-1:0] ptr_t;

  mbox_pkg::data_t mem_q [MailboxDepth];  // storage words
  ptr_t            rd_ptr_q, wr_ptr_q;
  logic [CntW-1:0] count_q;
  logic            do_push, do_pop;

  // step a pointer around the ring of any depth
  function automatic ptr_t next_ptr(input ptr_t p);
    if (p == ptr_t'(MailboxDepth - 1)) begin
      return '0;
    end
    return p + ptr_t'(1);
  endfunction

  assign full_o  = (count_q == CntW'(MailboxDepth));
  assign empty_o = (count_q == '0);
  assign data_o  = mem_q[rd_ptr_q];          // head of the queue

  assign do_push = push_i & ~full_o;         // overflow is dropped
  assign do_pop  = pop_i  & ~empty_o;

  // ----------------------------------------------------------------------
  // pointers and fill count
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (do_pop)  rd_ptr_q <= next_ptr(rd_ptr_q);
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + CntW'(1);
        2'b01:   count_q <= count_q - CntW'(1);
        default: count_q <= count_q;   // idle or push and pop together
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push && !flush_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // the ports have to look at full/empty before they strobe
  a_no_push_full: assert property (@(posedge clk_i) disable iff (reset_i)
    push_i |-> !full_o)
    else $error("mbox_fifo: push while full");

  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (reset_i)
    pop_i |-> !empty_o)
    else $error("mbox_fifo: pop while empty");

endmodule

//--- lite_resp_stage.sv
/*
 * Response stage holding one registered entry of an AXI-Lite R or B
 * channel so that a port never answers combinationally
 */
module lite_resp_stage #(
  parameter type T = logic  // channel payload
) (
  input  logic clk_i,
  input  logic reset_i,
  input  logic valid_i,  // entry from the port logic
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,  // towards the master
  input  logic ready_i,
  output T     data_o
);

  logic full_q;  // entry held
  T     data_q;  // held payload
  logic load;

  // ready when empty or when the held entry leaves this cycle
  assign ready_o = ~full_q | ready_i;
  assign load    = valid_i & ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      full_q <= 1'b0;
    end else if (load) begin
      full_q <= 1'b1;               // refill also while draining
    end else if (ready_i) begin
      full_q <= 1'b0;               // drained
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) data_q <= data_i;
  end

  assign valid_o = full_q;
  assign data_o  = data_q;

  // AXI wants the payload held while the master stalls
  a_stable_payload: assert property (@(posedge clk_i) disable iff (reset_i)
    (valid_o && !ready_i) |=> (valid_o && $stable(data_o)))
    else $error("lite_resp_stage: response changed under back-pressure");

endmodule

//--- mbox_port.sv
/*
 * Mailbox slave port: AXI-Lite decode of the mailbox register map, fifo
 * push/pop/flush control and the level error interrupt of one side
 */
module mbox_port (
  input  logic                clk_i,
  input  logic                reset_i,
  input  mbox_pkg::lite_req_t req_i,
  output mbox_pkg::lite_rsp_t rsp_o,
  // outbound fifo, this port writes
  input  logic                out_full_i,
  output logic                out_push_o,
  output mbox_pkg::data_t     out_data_o,
  output logic                out_flush_o,
  // inbound fifo, this port reads
  input  logic                in_empty_i,
  input  mbox_pkg::data_t     in_data_i,
  output logic                in_pop_o,
  output logic                in_flush_o,
  output logic                irq_o         // active high level
);

  localparam int unsigned IdxW = mbox_pkg::REG_IDX_W;

  mbox_pkg::r_chan_t r_chan, r_out;  // entry into / out of the R stage
  mbox_pkg::b_chan_t b_chan, b_out;
  logic              r_valid, r_ready, r_valid_q;
  logic              b_valid, b_ready, b_valid_q;
  logic              rd_acc, wr_acc;            // handshake edges
  logic [IdxW-1:0]   rd_idx, wr_idx;
  logic              rd_dec, wr_dec;            // index inside the map

  logic [1:0] error_q, error_d;  // {write full, read empty}
  logic       irqs_q, irqs_d;    // error irq status
  logic       irqen_q, irqen_d;
  logic       irqp;
  logic [1:0] status;
  logic       err_rd, err_wr;    // new errors this cycle
  logic       err_clr, irqs_clr;

  // ----------------------------------------------------------------------
  // decode and handshakes
  // ----------------------------------------------------------------------
  assign rd_idx = req_i.ar_addr[IdxW+1:2];  // word index
  assign wr_idx = req_i.aw_addr[IdxW+1:2];
  assign rd_dec = (rd_idx <= mbox_pkg::CTRL);
  assign wr_dec = (wr_idx <= mbox_pkg::CTRL);

  assign r_valid = req_i.ar_valid;
  assign rd_acc  = r_valid & r_ready;                  // R stage has room
  assign b_valid = req_i.aw_valid & req_i.w_valid;     // need both AW and W
  assign wr_acc  = b_valid & b_ready;

  assign status = {out_full_i, in_empty_i};
  assign irqp   = irqs_q & irqen_q;
  assign irq_o  = irqp;  // OR over the single error source

  // byte strobes mask the word that goes into the fifo
  always_comb begin
    for (int b = 0; b < mbox_pkg::STRB_W; b++) begin
      out_data_o[b*8 +: 8] = req_i.w_strb[b] ? req_i.w_data[b*8 +: 8] : 8'h00;
    end
  end

  // ----------------------------------------------------------------------
  // register access, read and write in one block so errors can be merged
  // ----------------------------------------------------------------------
  always_comb begin
    r_chan      = '{data: '0, resp: mbox_pkg::RESP_SLVERR};  // undecoded
    b_chan      = '{resp: mbox_pkg::RESP_SLVERR};
    in_pop_o    = 1'b0;
    out_push_o  = 1'b0;
    out_flush_o = 1'b0;
    in_flush_o  = 1'b0;
    err_rd      = 1'b0;
    err_wr      = 1'b0;
    err_clr     = 1'b0;
    irqs_clr    = 1'b0;
    irqen_d     = irqen_q;

    // read side, side effects only on acceptance
    if (rd_dec) begin
      unique case (mbox_pkg::reg_e'(rd_idx))
        mbox_pkg::MBOXW:
          r_chan = '{data: mbox_pkg::MBOXW_READ_WORD, resp: mbox_pkg::RESP_OKAY};
        mbox_pkg::MBOXR: begin
          if (!in_empty_i) begin
            r_chan   = '{data: in_data_i, resp: mbox_pkg::RESP_OKAY};
            in_pop_o = rd_acc;
          end else begin
            r_chan = '{data: mbox_pkg::EMPTY_READ_WORD, resp: mbox_pkg::RESP_SLVERR};
            err_rd = rd_acc;  // read empty
          end
        end
        mbox_pkg::STATUS:
          r_chan = '{data: mbox_pkg::data_t'(status), resp: mbox_pkg::RESP_OKAY};
        mbox_pkg::ERROR: begin
          r_chan  = '{data: mbox_pkg::data_t'(error_q), resp: mbox_pkg::RESP_OKAY};
          err_clr = rd_acc;   // clear on read
        end
        mbox_pkg::IRQS:
          r_chan = '{data: mbox_pkg::data_t'(irqs_q), resp: mbox_pkg::RESP_OKAY};
        mbox_pkg::IRQEN:
          r_chan = '{data: mbox_pkg::data_t'(irqen_q), resp: mbox_pkg::RESP_OKAY};
        mbox_pkg::IRQP:
          r_chan = '{data: mbox_pkg::data_t'(irqp), resp: mbox_pkg::RESP_OKAY};
        mbox_pkg::CTRL:
          r_chan = '{data: '0, resp: mbox_pkg::RESP_OKAY};  // flush bits self clear
        default: ;
      endcase
    end

    // write side, read only registers keep SLVERR
    if (wr_dec) begin
      unique case (mbox_pkg::reg_e'(wr_idx))
        mbox_pkg::MBOXW: begin
          if (!out_full_i) begin
            out_push_o = wr_acc;
            b_chan     = '{resp: mbox_pkg::RESP_OKAY};
          end else begin
            err_wr = wr_acc;  // write full
          end
        end
        mbox_pkg::IRQS: begin
          irqs_clr = wr_acc & req_i.w_strb[0] & req_i.w_data[0];  // write one to clear
          b_chan   = '{resp: mbox_pkg::RESP_OKAY};
        end
        mbox_pkg::IRQEN: begin
          if (wr_acc && req_i.w_strb[0]) irqen_d = req_i.w_data[0];
          b_chan = '{resp: mbox_pkg::RESP_OKAY};
        end
        mbox_pkg::CTRL: begin
          out_flush_o = wr_acc & req_i.w_strb[0] & req_i.w_data[0];
          in_flush_o  = wr_acc & req_i.w_strb[0] & req_i.w_data[1];
          b_chan      = '{resp: mbox_pkg::RESP_OKAY};
        end
        default: ;
      endcase
    end

    // clear first, then set: a new error survives a same-cycle clear
    error_d = (err_clr ? 2'b00 : error_q) | {err_wr, err_rd};
    irqs_d  = (irqs_q & ~irqs_clr) | err_wr | err_rd;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      error_q <= '0;
      irqs_q  <= 1'b0;
      irqen_q <= 1'b0;
    end else begin
      error_q <= error_d;
      irqs_q  <= irqs_d;
      irqen_q <= irqen_d;
    end
  end

  // ----------------------------------------------------------------------
  // registered R and B responses
  // ----------------------------------------------------------------------
  lite_resp_stage #(.T(mbox_pkg::r_chan_t)) i_r_stage (
    .clk_i,
    .reset_i,
    .valid_i ( r_valid       ),
    .ready_o ( r_ready       ),
    .data_i  ( r_chan        ),
    .valid_o ( r_valid_q     ),
    .ready_i ( req_i.r_ready ),
    .data_o  ( r_out         )
  );

  lite_resp_stage #(.T(mbox_pkg::b_chan_t)) i_b_stage (
    .clk_i,
    .reset_i,
    .valid_i ( b_valid       ),
    .ready_o ( b_ready       ),
    .data_i  ( b_chan        ),
    .valid_o ( b_valid_q     ),
    .ready_i ( req_i.b_ready ),
    .data_o  ( b_out         )
  );

  assign rsp_o = '{aw_ready: wr_acc,     w_ready: wr_acc,
                   b_valid:  b_valid_q,  b_resp:  b_out.resp,
                   ar_ready: rd_acc,     r_valid: r_valid_q,
                   r_data:   r_out.data, r_resp:  r_out.resp};

  // a pop only happens on a non-empty fifo and comes back as OKAY data
  a_pop_okay: assert property (@(posedge clk_i) disable iff (reset_i)
    in_pop_o |-> !in_empty_i ##1 (rsp_o.r_valid && rsp_o.r_resp == mbox_pkg::RESP_OKAY))
    else $error("mbox_port: bad pop or pop without OKAY response");

endmodule

//--- axi_lite_mailbox.sv
/*
 * Two-port AXI-Lite mailbox: two slave ports wired crosswise over two
 * FIFOs, fifo 0 carries port 0 to port 1 and fifo 1 the other way
 */
module axi_lite_mailbox #(
  parameter int unsigned MailboxDepth = 8  // words per direction, at least 2
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  mbox_pkg::lite_req_t [1:0] req_i,
  output mbox_pkg::lite_rsp_t [1:0] rsp_o,
  output logic                [1:0] irq_o   // one level irq per port
);

  // index of all these arrays is the port
  logic            [1:0] out_push, out_flush, out_full;  // towards own outbound fifo
  logic            [1:0] in_pop,   in_flush,  in_empty;  // towards own inbound fifo
  mbox_pkg::data_t [1:0] out_data, in_data;

  // ----------------------------------------------------------------------
  // slave ports
  // ----------------------------------------------------------------------
  for (genvar p = 0; p < 2; p++) begin : gen_port
    mbox_port i_port (
      .clk_i,
      .reset_i,
      .req_i       ( req_i[p]     ),
      .rsp_o       ( rsp_o[p]     ),
      .out_full_i  ( out_full[p]  ),
      .out_push_o  ( out_push[p]  ),
      .out_data_o  ( out_data[p]  ),
      .out_flush_o ( out_flush[p] ),
      .in_empty_i  ( in_empty[p]  ),
      .in_data_i   ( in_data[p]   ),
      .in_pop_o    ( in_pop[p]    ),
      .in_flush_o  ( in_flush[p]  ),
      .irq_o       ( irq_o[p]     )
    );
  end

  // ----------------------------------------------------------------------
  // fifo f is written by port f and read by port 1-f
  // ----------------------------------------------------------------------
  for (genvar f = 0; f < 2; f++) begin : gen_fifo
    mbox_fifo #(
      .MailboxDepth ( MailboxDepth )
    ) i_fifo (
      .clk_i,
      .reset_i,
      .push_i  ( out_push[f]                   ),
      .pop_i   ( in_pop[1-f]                   ),
      .flush_i ( out_flush[f] | in_flush[1-f]  ),  // either side may flush
      .data_i  ( out_data[f]                   ),
      .data_o  ( in_data[1-f]                  ),
      .full_o  ( out_full[f]                   ),
      .empty_o ( in_empty[1-f]                 )
    );
  end

endmodule

//--- mbox_checker.sv
/*
 * Mailbox checker that watches the R and B handshakes and the irq lines
 * of the DUT and compares them with the expected fields of the current row
 */
module mbox_checker (
  input  logic                      clk_i,
  input  mbox_pkg::lite_req_t [1:0] req_i,
  input  mbox_pkg::lite_rsp_t [1:0] rsp_i,
  input  logic                [1:0] irq_i,
  input  int unsigned               row_i,       // row under test
  input  logic                      port_i,
  input  logic                      write_i,
  input  mbox_pkg::data_t           exp_data_i,
  input  logic                [1:0] exp_resp_i,
  input  logic                      exp_irq_i,
  input  logic                      finish_i,    // stimulus done
  input  int unsigned               timeouts_i,
  output int unsigned               checked_o,
  output int unsigned               failed_o
);

  int unsigned checked_q;
  int unsigned failed_q;

  initial begin
    checked_q = 0;
    failed_q  = 0;
  end

  assign checked_o = checked_q;
  assign failed_o  = failed_q;

  // compare one field and print a Fail line on mismatch
  function automatic logic field_ok(input string name, input logic [31:0] exp,
                                    input logic [31:0] act);
    if (exp !== act) begin
      $display("Fail row %0d port %0d %s expected %h actual %h",
               row_i, port_i, name, exp, act);
      return 1'b0;
    end
    return 1'b1;
  endfunction

  // ----------------------------------------------------------------------
  // compare at the response handshake of the current port
  // ----------------------------------------------------------------------
  always @(posedge clk_i) begin
    logic hit;
    logic ok;
    // aw_ready and w_ready rise together on every port
    for (int p = 0; p < 2; p++) begin
      if (rsp_i[p].w_ready !== rsp_i[p].aw_ready) begin
        $display("Fail port %0d w_ready expected %h actual %h",
                 p, rsp_i[p].aw_ready, rsp_i[p].w_ready);
        failed_q++;
      end
    end
    hit = write_i ? (rsp_i[port_i].b_valid & req_i[port_i].b_ready)
                  : (rsp_i[port_i].r_valid & req_i[port_i].r_ready);
    if (hit) begin
      ok = 1'b1;
      if (write_i) begin
        ok &= field_ok("b_resp", 32'(exp_resp_i), 32'(rsp_i[port_i].b_resp));
      end else begin
        ok &= field_ok("r_data", exp_data_i, rsp_i[port_i].r_data);
        ok &= field_ok("r_resp", 32'(exp_resp_i), 32'(rsp_i[port_i].r_resp));
      end
      ok &= field_ok("irq_o", 32'(exp_irq_i), 32'(irq_i[port_i]));  // level after accept
      checked_q++;
      if (!ok) failed_q++;
      $display("row %0d port %0d %s %s", row_i, port_i,
               write_i ? "write" : "read", ok ? "ok" : "failed");
    end
  end

  always @(posedge finish_i) begin
    $display("rows checked %0d, failed %0d, timeouts %0d",
             checked_q, failed_q, timeouts_i);
  end

endmodule

//--- tb_mailbox.sv
/*
 * Mailbox testbench that applies a table of register accesses to both
 * ports of the mailbox while mbox_checker compares the responses
 */
module tb_mailbox;

  localparam int unsigned num_rows   = 36;
  localparam int unsigned wait_limit = 64;      // cycles per handshake wait

  localparam logic       rd_op  = 1'b0;
  localparam logic       wr_op  = 1'b1;
  localparam logic [1:0] okay   = 2'b00;
  localparam logic [1:0] slverr = 2'b10;

  // one bus access and what it should return
  typedef struct packed {
    logic        port;
    logic        write;
    logic [3:0]  idx;       // register index from word address bits 5:2
    logic [31:0] wdata;
    logic [3:0]  strb;
    logic [31:0] exp_data;  // reads only
    logic [1:0]  exp_resp;
    logic        exp_irq;   // irq of the same port at the response
  } row_t;

  logic                      clk;
  logic                      reset;
  mbox_pkg::lite_req_t [1:0] req;
  mbox_pkg::lite_rsp_t [1:0] rsp;
  logic                [1:0] irq;
  row_t                      cur;       // row under test as seen by the checker
  int unsigned               row_num;
  int unsigned               timeouts;
  int unsigned               checked;
  int unsigned               failed;
  logic                      finish;

  // ----------------------------------------------------------------------
  // stimulus table for a fifo depth of 4
  // ----------------------------------------------------------------------
  row_t rows [num_rows] = '{
    '{1'b1, rd_op, 4'd2, 32'h0, 4'h0, 32'h0000_0001, okay,   1'b0},  // p1 status shows empty
    '{1'b1, rd_op, 4'd1, 32'h0, 4'h0, 32'hFEED_DEAD, slverr, 1'b0},  // empty pop
    '{1'b1, rd_op, 4'd3, 32'h0, 4'h0, 32'h0000_0001, okay,   1'b0},  // read empty flag
    '{1'b1, rd_op, 4'd3, 32'h0, 4'h0, 32'h0000_0000, okay,   1'b0},  // cleared by read
    '{1'b1, wr_op, 4'd4, 32'h0000_0001, 4'hF, 32'h0, okay,   1'b0},  // irqs w1c
    '{1'b1, rd_op, 4'd0, 32'h0, 4'h0, 32'hFEED_C0DE, okay,   1'b0},  // mboxw marker
    '{1'b0, wr_op, 4'd0, 32'h1111_1111, 4'hF, 32'h0, okay,   1'b0},
    '{1'b0, wr_op, 4'd0, 32'h2222_2222, 4'h3, 32'h0, okay,   1'b0},  // low half only
    '{1'b0, wr_op, 4'd0, 32'h3333_3333, 4'hF, 32'h0, okay,   1'b0},
    '{1'b0, wr_op, 4'd0, 32'h4444_4444, 4'hF, 32'h0, okay,   1'b0},  // now full
    '{1'b0, rd_op, 4'd2, 32'h0, 4'h0, 32'h0000_0003, okay,   1'b0},  // full and empty
    '{1'b0, wr_op, 4'd5, 32'h0000_0001, 4'hF, 32'h0, okay,   1'b0},  // irq enable
    '{1'b0, wr_op, 4'd0, 32'h5555_5555, 4'hF, 32'h0, slverr, 1'b1},  // overflow
    '{1'b0, rd_op, 4'd3, 32'h0, 4'h0, 32'h0000_0002, okay,   1'b1},  // write full flag
    '{1'b0, rd_op, 4'd3, 32'h0, 4'h0, 32'h0000_0000, okay,   1'b1},
    '{1'b0, rd_op, 4'd6, 32'h0, 4'h0, 32'h0000_0001, okay,   1'b1},  // pending
    '{1'b0, wr_op, 4'd4, 32'h0000_0001, 4'hF, 32'h0, okay,   1'b0},  // irq drops
    '{1'b1, rd_op, 4'd1, 32'h0, 4'h0, 32'h1111_1111, okay,   1'b0},  // fifo order
    '{1'b1, rd_op, 4'd1, 32'h0, 4'h0, 32'h0000_2222, okay,   1'b0},
    '{1'b1, rd_op, 4'd2, 32'h0, 4'h0, 32'h0000_0000, okay,   1'b0},  // two words left
    '{1'b0, wr_op, 4'd7, 32'h0000_0001, 4'hF, 32'h0, okay,   1'b0},  // flush outbound
    '{1'b1, rd_op, 4'd2, 32'h0, 4'h0, 32'h0000_0001, okay,   1'b0},  // empty again
    '{1'b1, rd_op, 4'd1, 32'h0, 4'h0, 32'hFEED_DEAD, slverr, 1'b0},  // irq off on p1
    '{1'b1, wr_op, 4'd0, 32'hAAAA_5555, 4'hF, 32'h0, okay,   1'b0},  // other direction
    '{1'b1, wr_op, 4'd0, 32'h1234_5678, 4'h3, 32'h0, okay,   1'b0},
    '{1'b0, rd_op, 4'd2, 32'h0, 4'h0, 32'h0000_0000, okay,   1'b0},
    '{1'b0, rd_op, 4'd1, 32'h0, 4'h0, 32'hAAAA_5555, okay,   1'b0},
    '{1'b0, rd_op, 4'd1, 32'h0, 4'h0, 32'h0000_5678, okay,   1'b0},
    '{1'b0, rd_op, 4'd2, 32'h0, 4'h0, 32'h0000_0001, okay,   1'b0},
    '{1'b0, wr_op, 4'd8, 32'h0000_0001, 4'hF, 32'h0, slverr, 1'b0},  // undecoded
    '{1'b0, rd_op, 4'd12, 32'h0, 4'h0, 32'h0000_0000, slverr, 1'b0},
    '{1'b0, rd_op, 4'd5, 32'h0, 4'h0, 32'h0000_0001, okay,   1'b0},  // enable kept
    '{1'b0, rd_op, 4'd3, 32'h0, 4'h0, 32'h0000_0000, okay,   1'b0},
    '{1'b1, rd_op, 4'd3, 32'h0, 4'h0, 32'h0000_0001, okay,   1'b0},  // from empty pop
    '{1'b1, wr_op, 4'd12, 32'h0000_0001, 4'hF, 32'h0, slverr, 1'b0}, // irqs alias if bit 3 lost
    '{1'b1, rd_op, 4'd4, 32'h0, 4'h0, 32'h0000_0001, okay,   1'b0}   // irqs still set
  };

  axi_lite_mailbox #(
    .MailboxDepth ( 4 )
  ) UUT (
    .clk_i   ( clk   ),
    .reset_i ( reset ),
    .req_i   ( req   ),
    .rsp_o   ( rsp   ),
    .irq_o   ( irq   )
  );

  mbox_checker i_checker (
    .clk_i      ( clk          ),
    .req_i      ( req          ),
    .rsp_i      ( rsp          ),
    .irq_i      ( irq          ),
    .row_i      ( row_num      ),
    .port_i     ( cur.port     ),
    .write_i    ( cur.write    ),
    .exp_data_i ( cur.exp_data ),
    .exp_resp_i ( cur.exp_resp ),
    .exp_irq_i  ( cur.exp_irq  ),
    .finish_i   ( finish       ),
    .timeouts_i ( timeouts     ),
    .checked_o  ( checked      ),
    .failed_o   ( failed       )
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // one access with request, ready wait and a randomly stalled response
  // ----------------------------------------------------------------------
  task automatic run_row(input row_t r);
    int unsigned waited;
    int unsigned hold;
    logic        hit;
    hold = $urandom % 4;  // master stalls the response 0..3 cycles
    if (r.write) begin
      req[r.port].aw_valid = 1'b1;
      req[r.port].aw_addr  = {r.idx, 2'b00};
      req[r.port].w_valid  = 1'b1;
      req[r.port].w_data   = r.wdata;
      req[r.port].w_strb   = r.strb;
    end else begin
      req[r.port].ar_valid = 1'b1;
      req[r.port].ar_addr  = {r.idx, 2'b00};
    end
    waited = 0;
    hit    = 1'b0;
    while (!hit && waited < wait_limit) begin
      @(posedge clk);
      hit = r.write ? rsp[r.port].aw_ready : rsp[r.port].ar_ready;
      waited++;
    end
    @(negedge clk);
    req[r.port].aw_valid = 1'b0;
    req[r.port].w_valid  = 1'b0;
    req[r.port].ar_valid = 1'b0;
    if (!hit) begin
      $display("timeout: port %0d never accepted the request of row %0d", r.port, row_num);
      timeouts++;
    end else begin
      repeat (hold) @(negedge clk);
      req[r.port].b_ready = r.write;
      req[r.port].r_ready = ~r.write;
      waited = 0;
      hit    = 1'b0;
      while (!hit && waited < wait_limit) begin
        @(posedge clk);
        hit = r.write ? rsp[r.port].b_valid : rsp[r.port].r_valid;
        waited++;
      end
      @(negedge clk);
      req[r.port].b_ready = 1'b0;
      req[r.port].r_ready = 1'b0;
      if (!hit) begin
        $display("timeout: port %0d gave no response for row %0d", r.port, row_num);
        timeouts++;
      end
    end
  endtask

  initial begin
    void'($urandom(32'h6fe1_dede));  // single seed for the run
    reset    = 1'b1;
    req      = '0;
    cur      = '0;
    row_num  = 0;
    timeouts = 0;
    finish   = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    // the bus state is unknown after a timeout so the loop stops there
    for (int i = 0; i < num_rows && timeouts == 0; i++) begin
      row_num = i;
      cur     = rows[i];
      run_row(rows[i]);
    end
    finish = 1'b1;  // checker prints the counts
    @(posedge clk);
    if (failed == 0 && timeouts == 0 && checked == num_rows) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- filelist.f
mbox_pkg.sv
mbox_fifo.sv
lite_resp_stage.sv
mbox_port.sv
axi_lite_mailbox.sv
mbox_checker.sv
tb_mailbox.sv

//--- run.sh
#!/bin/sh
# build and run the mailbox testbench with Verilator
# exit status is nonzero when the build, the run or a check fails

cd "$(dirname "$0")" || exit 1

top=tb_mailbox
log=sim.log

# compile into obj_dir, --binary gives a timed executable
if ! verilator --binary --assert --top-module "$top" -f filelist.f; then
  echo "verilator build failed"
  exit 1
fi

# run and keep the output for the search below
if ! "./obj_dir/V$top" > "$log" 2>&1; then
  cat "$log"
  echo "simulation did not end cleanly"
  exit 1
fi
cat "$log"

if grep -q "STATUS: FAIL" "$log"; then
  exit 1
fi
exit 0
